//--- index_gen_pkg.sv
// ------------------------------
// Index generator shared types
// Widths, register map, sweep config, request and AXI4-Lite bundles
// ------------------------------
package index_gen_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;
    localparam int INDEX_W     = 32;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // ------------------------------
    // Register map
    // ------------------------------
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_BASE   = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_START  = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_END    = 8'h10;
    localparam logic [AXIL_ADDR_W-1:0] REG_STRIDE = 8'h14;
    localparam logic [AXIL_ADDR_W-1:0] REG_SHAPE  = 8'h18;

    // Sweep setup as written by software
    typedef struct packed {
        logic [INDEX_W-1:0] base;
        logic [INDEX_W-1:0] index_start;
        logic [INDEX_W-1:0] index_end;
        logic [INDEX_W-1:0] stride;
        logic               decrement;
        logic               shift_left;
        logic [4:0]         shift_amount;
    } sweep_cfg_t;

    // One memory request
    typedef struct packed {
        logic [INDEX_W-1:0] base;
        logic [INDEX_W-1:0] offset;
        logic [INDEX_W-1:0] index;
    } index_req_t;

    // Master to slave
    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

//--- index_gen_csr.sv
// ------------------------------
// AXI4-Lite register block
// Holds the sweep setup, issues start and reports busy/done
// ------------------------------
`timescale 1ns/1ns

module index_gen_csr (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  index_gen_pkg::axil_req_t  s_axil,
    output index_gen_pkg::axil_rsp_t  s_axil_rsp,
    output index_gen_pkg::sweep_cfg_t cfg,
    output logic                      start,
    input  logic                      busy,
    input  logic                      done
);

    logic                                  wr_accept;
    logic                                  rd_accept;
    logic                                  bvalid;
    logic                                  rvalid;
    logic                                  done_flag;
    logic [index_gen_pkg::AXIL_DATA_W-1:0] rdata;
    logic [index_gen_pkg::AXIL_DATA_W-1:0] rdata_next;

    // Address and data taken together, one outstanding response each way
    assign wr_accept = s_axil.awvalid & s_axil.wvalid & ~bvalid;
    assign rd_accept = s_axil.arvalid & ~rvalid;

    always_comb begin
        s_axil_rsp.awready = wr_accept;
        s_axil_rsp.wready  = wr_accept;
        s_axil_rsp.bvalid  = bvalid;
        s_axil_rsp.bresp   = index_gen_pkg::AXIL_RESP_OKAY;
        s_axil_rsp.arready = ~rvalid;
        s_axil_rsp.rvalid  = rvalid;
        s_axil_rsp.rdata   = rdata;
        s_axil_rsp.rresp   = index_gen_pkg::AXIL_RESP_OKAY;
    end

    // ------------------------------
    // Write path
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (s_axil.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg <= '0;
        end else if (wr_accept) begin
            case (s_axil.awaddr)
                index_gen_pkg::REG_BASE:   cfg.base        <= s_axil.wdata;
                index_gen_pkg::REG_START:  cfg.index_start <= s_axil.wdata;
                index_gen_pkg::REG_END:    cfg.index_end   <= s_axil.wdata;
                index_gen_pkg::REG_STRIDE: cfg.stride      <= s_axil.wdata;
                index_gen_pkg::REG_SHAPE: begin
                    cfg.decrement    <= s_axil.wdata[0];
                    cfg.shift_left   <= s_axil.wdata[1];
                    cfg.shift_amount <= s_axil.wdata[8:4];
                end
                default: ;
            endcase
        end
    end

    // Start pulse; a running sweep or a pulse in flight blocks a new one
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start <= 1'b0;
        end else begin
            start <= wr_accept && (s_axil.awaddr == index_gen_pkg::REG_CTRL) &&
                     s_axil.wdata[0] && !busy && !start;
        end
    end

    // Sticky done, cleared by the next sweep
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            done_flag <= 1'b0;
        end else if (done) begin
            done_flag <= 1'b1;
        end else if (start) begin
            done_flag <= 1'b0;
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        rdata_next = '0;
        case (s_axil.araddr)
            index_gen_pkg::REG_CTRL:   rdata_next[0] = start;
            index_gen_pkg::REG_STATUS: begin
                rdata_next[0] = busy;
                // Done pulse shows up before the sticky bit catches it
                rdata_next[1] = done_flag | done;
            end
            index_gen_pkg::REG_BASE:   rdata_next = cfg.base;
            index_gen_pkg::REG_START:  rdata_next = cfg.index_start;
            index_gen_pkg::REG_END:    rdata_next = cfg.index_end;
            index_gen_pkg::REG_STRIDE: rdata_next = cfg.stride;
            index_gen_pkg::REG_SHAPE: begin
                rdata_next[0]   = cfg.decrement;
                rdata_next[1]   = cfg.shift_left;
                rdata_next[8:4] = cfg.shift_amount;
            end
            default: rdata_next = '0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (s_axil.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rd_accept) begin
            rdata <= rdata_next;
        end
    end

    // Write response stays up until the master takes it
    a_bvalid_hold: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        bvalid && !s_axil.bready |=> bvalid
    );

endmodule

//--- index_sequencer.sv
// ------------------------------
// Index sequencer
// Steps through the index range and emits one request per index
// ------------------------------
`timescale 1ns/1ns

module index_sequencer #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  index_gen_pkg::sweep_cfg_t cfg,
    input  logic                      start,
    output logic                      busy,
    output logic                      done,
    output logic                      push,
    output index_gen_pkg::index_req_t push_data,
    input  logic                      prog_full
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        PAUSE,
        FINISH
    } state_t;

    state_t                              state;
    state_t                              state_next;
    index_gen_pkg::sweep_cfg_t           cfg_q;
    logic [COUNT_WIDTH-1:0]              count;
    logic [COUNT_WIDTH-1:0]              count_end;
    logic [COUNT_WIDTH-1:0]              count_stride;
    logic [COUNT_WIDTH:0]                step_wide;
    logic                                in_range;
    logic                                step_in_range;
    logic                                active;
    logic [index_gen_pkg::INDEX_W-1:0]   index_val;

    assign count_end    = COUNT_WIDTH'(cfg_q.index_end);
    assign count_stride = COUNT_WIDTH'(cfg_q.stride);

    // ------------------------------
    // Range test on current and next count
    // ------------------------------
    // Top bit of step_wide flags a wrap past zero or past the counter width
    always_comb begin
        if (cfg_q.decrement) begin
            step_wide     = {1'b0, count} - {1'b0, count_stride};
            in_range      = count > count_end;
            step_in_range = !step_wide[COUNT_WIDTH] &&
                            (step_wide[COUNT_WIDTH-1:0] > count_end);
        end else begin
            step_wide     = {1'b0, count} + {1'b0, count_stride};
            in_range      = count < count_end;
            step_in_range = !step_wide[COUNT_WIDTH] &&
                            (step_wide[COUNT_WIDTH-1:0] < count_end);
        end
    end

    assign active = (state == RUN) || (state == PAUSE);
    assign push   = active && in_range && !prog_full;
    assign busy   = (state != IDLE);
    assign done   = (state == FINISH);

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE:   if (start) state_next = LOAD;
            LOAD:   state_next = RUN;
            RUN, PAUSE: begin
                if (!in_range) begin
                    state_next = FINISH;
                end else if (prog_full) begin
                    state_next = PAUSE;
                end else if (!step_in_range) begin
                    state_next = FINISH;
                end else begin
                    state_next = RUN;
                end
            end
            FINISH: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Setup snapshot and stride counter
    always_ff @(posedge ap_clk) begin
        if (state == IDLE && start) begin
            cfg_q <= cfg;
        end
        if (state == LOAD) begin
            count <= COUNT_WIDTH'(cfg_q.index_start);
        end else if (push) begin
            count <= step_wide[COUNT_WIDTH-1:0];
        end
    end

    // Request packet
    assign index_val       = index_gen_pkg::INDEX_W'(count);
    assign push_data.base  = cfg_q.base;
    assign push_data.index = index_val;
    assign push_data.offset = cfg_q.shift_left ? (index_val << cfg_q.shift_amount)
                                               : (index_val >> cfg_q.shift_amount);

    a_no_push_prog_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        prog_full |-> !push
    );

    // CSR is expected to hold start off while a sweep runs
    a_start_in_idle: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        start |-> state == IDLE
    );

endmodule

//--- request_fifo.sv
// ------------------------------
// Request FIFO
// Circular buffer with programmable full and valid/ready output
// ------------------------------
`timescale 1ns/1ns

module request_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      push,
    input  index_gen_pkg::index_req_t push_data,
    output logic                      prog_full,
    output logic                      req_valid,
    output index_gen_pkg::index_req_t req,
    input  logic                      req_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    index_gen_pkg::index_req_t mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          occupancy;
    logic                      pop;
    logic                      full;

    assign pop       = req_valid & req_ready;
    assign full      = (occupancy == CNT_W'(DEPTH));
    assign req_valid = (occupancy != '0);
    assign prog_full = (occupancy >= CNT_W'(PROG_THRESH));
    assign req       = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push |-> !full
    );

    // Stalled head entry must not move
    a_stall_stable: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        req_valid && !req_ready |=> req_valid && $stable(req)
    );

endmodule

//--- index_gen_top.sv
// ------------------------------
// CSR index generator top level
// Register block, sequencer and request FIFO
// ------------------------------
`timescale 1ns/1ns

module index_gen_top #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8,
    parameter int COUNT_WIDTH = 32
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  index_gen_pkg::axil_req_t  s_axil,
    output index_gen_pkg::axil_rsp_t  s_axil_rsp,
    output logic                      req_valid,
    output index_gen_pkg::index_req_t req,
    input  logic                      req_ready
);

    index_gen_pkg::sweep_cfg_t cfg;
    index_gen_pkg::index_req_t push_data;
    logic                      start;
    logic                      busy;
    logic                      done;
    logic                      push;
    logic                      prog_full;

    index_gen_csr csr_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .s_axil          (s_axil),
        .s_axil_rsp      (s_axil_rsp),
        .cfg             (cfg),
        .start           (start),
        .busy            (busy),
        .done            (done)
    );

    index_sequencer #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) sequencer_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg             (cfg),
        .start           (start),
        .busy            (busy),
        .done            (done),
        .push            (push),
        .push_data       (push_data),
        .prog_full       (prog_full)
    );

    // Threshold leaves room for the push already under way
    request_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (push),
        .push_data       (push_data),
        .prog_full       (prog_full),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready)
    );

endmodule

//--- tb_index_gen.sv
// ------------------------------
// Index generator testbench
// Random sweeps checked against a queue model, with AXI4-Lite setup
// ------------------------------
`timescale 1ns/1ns

module tb_index_gen;

    localparam int AXIL_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int POLL_LIMIT    = 50;
    localparam int QUIET_CYCLES  = 20;

    logic                      ap_clk = 1'b0;
    logic                      areset_generator = 1'b1;
    index_gen_pkg::axil_req_t  s_axil = '0;
    index_gen_pkg::axil_rsp_t  s_axil_rsp;
    logic                      req_valid;
    index_gen_pkg::index_req_t req;
    logic                      req_ready = 1'b0;

    integer                    seed = 32'h54d0;
    index_gen_pkg::index_req_t expected_q[$];
    index_gen_pkg::index_req_t exp_req;
    // 0 always ready, 1 random stalls, 2 held off
    int                        bp_mode = 0;
    int                        stall_left = 0;
    logic [31:0]               roll;

    index_gen_top index_gen_top_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .s_axil          (s_axil),
        .s_axil_rsp      (s_axil_rsp),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready)
    );

    always #4 ap_clk = ~ap_clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                                        $time, what, got, expected));
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    // ------------------------------
    // AXI4-Lite master
    // ------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        s_axil.awvalid <= 1'b1;
        s_axil.awaddr  <= addr;
        s_axil.wvalid  <= 1'b1;
        s_axil.wdata   <= data;
        s_axil.wstrb   <= 4'hF;
        @(negedge ap_clk);
        while (!s_axil_rsp.awready) begin
            if (waited >= AXIL_TIMEOUT) begin
                stop_with_failure("The AXI4-Lite write was never accepted");
            end else begin
                waited++;
                @(negedge ap_clk);
            end
        end
        check_equal("wready with awready", s_axil_rsp.wready, 1);
        @(posedge ap_clk);
        s_axil.awvalid <= 1'b0;
        s_axil.wvalid  <= 1'b0;
        s_axil.bready  <= 1'b1;
        waited = 0;
        @(negedge ap_clk);
        while (!s_axil_rsp.bvalid) begin
            if (waited >= AXIL_TIMEOUT) begin
                stop_with_failure("No AXI4-Lite write response arrived");
            end else begin
                waited++;
                @(negedge ap_clk);
            end
        end
        check_equal("bresp", s_axil_rsp.bresp, 0);
        @(posedge ap_clk);
        s_axil.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        s_axil.arvalid <= 1'b1;
        s_axil.araddr  <= addr;
        @(negedge ap_clk);
        while (!s_axil_rsp.arready) begin
            if (waited >= AXIL_TIMEOUT) begin
                stop_with_failure("The AXI4-Lite read was never accepted");
            end else begin
                waited++;
                @(negedge ap_clk);
            end
        end
        @(posedge ap_clk);
        s_axil.arvalid <= 1'b0;
        s_axil.rready  <= 1'b1;
        waited = 0;
        @(negedge ap_clk);
        while (!s_axil_rsp.rvalid) begin
            if (waited >= AXIL_TIMEOUT) begin
                stop_with_failure("No AXI4-Lite read data arrived");
            end else begin
                waited++;
                @(negedge ap_clk);
            end
        end
        check_equal("rresp", s_axil_rsp.rresp, 0);
        data = s_axil_rsp.rdata;
        @(posedge ap_clk);
        s_axil.rready <= 1'b0;
    endtask

    // ------------------------------
    // Stream side
    // ------------------------------
    always @(posedge ap_clk) begin
        if (bp_mode == 0) begin
            req_ready <= 1'b1;
        end else if (bp_mode == 2) begin
            req_ready <= 1'b0;
        end else if (stall_left != 0) begin
            req_ready <= 1'b0;
            stall_left--;
        end else begin
            roll = $random(seed);
            if (roll[3:0] == 4'd0) begin
                // Longer than the FIFO depth
                stall_left = 17 + int'(roll[8:4]);
                req_ready <= 1'b0;
            end else begin
                req_ready <= (roll[3:0] > 4'd4);
            end
        end
    end

    // Pops are sampled mid-cycle, away from the driving edge
    always @(negedge ap_clk) begin
        if (!areset_generator && req_valid && req_ready) begin
            if (expected_q.size() == 0) begin
                stop_with_failure("An unexpected request appeared on the output stream");
            end else begin
                exp_req = expected_q.pop_front();
                check_equal("req.index", req.index, exp_req.index);
                check_equal("req.offset", req.offset, exp_req.offset);
                check_equal("req.base", req.base, exp_req.base);
            end
        end
    end

    // Expected stream from the sweep rules
    task automatic load_model(input index_gen_pkg::sweep_cfg_t c);
        longint                    idx;
        longint                    end_val;
        longint                    step;
        index_gen_pkg::index_req_t r;
        expected_q.delete();
        idx     = longint'(c.index_start);
        end_val = longint'(c.index_end);
        step    = longint'(c.stride);
        while (c.decrement ? (idx > end_val) : (idx < end_val)) begin
            r.base   = c.base;
            r.index  = idx[31:0];
            r.offset = c.shift_left ? (r.index << c.shift_amount)
                                    : (r.index >> c.shift_amount);
            expected_q.push_back(r);
            idx = c.decrement ? idx - step : idx + step;
        end
    endtask

    function automatic index_gen_pkg::sweep_cfg_t random_cfg(input logic dec,
                                                             input int unsigned min_count);
        index_gen_pkg::sweep_cfg_t c;
        int unsigned               n;
        c.base         = $random(seed);
        c.stride       = 1 + rand_below(7);
        c.decrement    = dec;
        c.shift_left   = (rand_below(2) == 1);
        c.shift_amount = 5'(rand_below(32));
        n              = min_count + rand_below(20);
        c.index_end    = rand_below(5000);
        c.index_start  = rand_below(5000);
        if (dec) begin
            c.index_start = c.index_end + c.stride * n - rand_below(c.stride);
        end else begin
            c.index_end = c.index_start + c.stride * n - rand_below(c.stride);
        end
        return c;
    endfunction

    task automatic program_sweep(input index_gen_pkg::sweep_cfg_t c);
        axil_write(index_gen_pkg::REG_BASE, c.base);
        axil_write(index_gen_pkg::REG_START, c.index_start);
        axil_write(index_gen_pkg::REG_END, c.index_end);
        axil_write(index_gen_pkg::REG_STRIDE, c.stride);
        axil_write(index_gen_pkg::REG_SHAPE,
                   {23'd0, c.shift_amount, 2'b00, c.shift_left, c.decrement});
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                stop_with_failure("Expected requests were still missing at the timeout");
            end else begin
                waited++;
                @(negedge ap_clk);
            end
        end
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        axil_read(index_gen_pkg::REG_STATUS, status);
        while (!status[1]) begin
            if (polls >= POLL_LIMIT) begin
                stop_with_failure("STATUS.done never went high after the sweep");
            end else begin
                polls++;
                axil_read(index_gen_pkg::REG_STATUS, status);
            end
        end
    endtask

    // Nothing may follow the finished sweep
    task automatic finish_sweep();
        int k;
        bp_mode = 0;
        wait_for_drain();
        wait_for_done();
        for (k = 0; k < QUIET_CYCLES; k++) begin
            @(negedge ap_clk);
            check_equal("req_valid after sweep", req_valid, 0);
        end
    endtask

    task automatic run_sweep(input index_gen_pkg::sweep_cfg_t c, input int bp);
        program_sweep(c);
        load_model(c);
        bp_mode = bp;
        axil_write(index_gen_pkg::REG_CTRL, 32'h1);
        if (bp != 0) begin
            wait_for_drain();
        end
        finish_sweep();
    endtask

    task automatic test_register_readback();
        logic [31:0] value;
        logic [31:0] data;
        logic [7:0]  addr;
        int          i;
        for (i = 0; i < 4; i++) begin
            addr  = index_gen_pkg::REG_BASE + 8'(4 * i);
            value = $random(seed);
            axil_write(addr, value);
            axil_read(addr, data);
            check_equal("register readback", data, value);
        end
        // Only the defined SHAPE fields are stored
        value = $random(seed);
        axil_write(index_gen_pkg::REG_SHAPE, value);
        axil_read(index_gen_pkg::REG_SHAPE, data);
        check_equal("SHAPE readback", data, value & 32'h0000_01F3);
        axil_read(8'h1C, data);
        check_equal("unknown address 0x1C", data, 0);
        axil_read(8'h80, data);
        check_equal("unknown address 0x80", data, 0);
        axil_read(8'hFC, data);
        check_equal("unknown address 0xFC", data, 0);
    endtask

    task automatic test_status_and_restart();
        index_gen_pkg::sweep_cfg_t c;
        logic [31:0]               status;
        c = random_cfg(1'b0, 50);
        program_sweep(c);
        load_model(c);
        // Stream held off so the sweep stays busy
        bp_mode = 2;
        axil_write(index_gen_pkg::REG_CTRL, 32'h1);
        axil_read(index_gen_pkg::REG_STATUS, status);
        check_equal("STATUS.busy during sweep", status[0], 1);
        check_equal("STATUS.done after new start", status[1], 0);
        axil_write(index_gen_pkg::REG_CTRL, 32'h1);
        axil_read(index_gen_pkg::REG_STATUS, status);
        check_equal("STATUS.busy after second start", status[0], 1);
        bp_mode = 1;
        wait_for_drain();
        finish_sweep();
    endtask

    task automatic test_empty_range();
        index_gen_pkg::sweep_cfg_t c;
        c = random_cfg(1'b0, 1);
        c.index_start = c.index_end + rand_below(10);
        run_sweep(c, 0);
        c = random_cfg(1'b1, 1);
        c.index_end   = 10 + rand_below(1000);
        c.index_start = c.index_end - rand_below(10);
        run_sweep(c, 0);
    endtask

    initial begin
        int round;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        test_register_readback();
        for (round = 0; round < 5; round++) begin
            run_sweep(random_cfg(1'b0, 1), 0);
        end
        for (round = 0; round < 5; round++) begin
            run_sweep(random_cfg(1'b1, 1), 0);
        end
        for (round = 0; round < 4; round++) begin
            run_sweep(random_cfg(round % 2 == 1, 40), 1);
        end
        test_status_and_restart();
        test_empty_range();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim.f
index_gen_pkg.sv
index_gen_csr.sv
index_sequencer.sv
request_fifo.sv
index_gen_top.sv
tb_index_gen.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_index_gen
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
